/* run.sh */
#!/bin/sh
# Build with Verilator, run, and scan the log for failure
rm -f run.log
verilator --binary --timing --assert --top-module tb_exec_unit -f tb.f -Mdir obj_dir -o sim \
  > run.log 2>&1 &&
./obj_dir/sim +verilator+error+limit+10000 >> run.log 2>&1 ||
echo "CHECKS FAILED" >> run.log
cat run.log
grep -q "CHECKS FAILED" run.log && exit 1 || exit 0

/* src/exec_alu.sv */
// Two-operand ALU
module exec_alu (
  input  exec_pkg::alu_op_t   inst_op,
  input  logic                inst_bw,      // Byte width
  input  logic [15:0]         op_src,
  input  logic [15:0]         op_dst,
  input  exec_pkg::flags_t    status,       // Current r2 flags
  output logic [15:0]         alu_out,
  output logic [15:0]         alu_out_add,  // Address sum
  output exec_pkg::flags_t    alu_stat
);

  // ==============================
  // Adder
  // ==============================
  logic        sub_op;
  logic        arith_op;
  logic [15:0] add_b;                       // Second adder input
  logic        cin;
  logic [16:0] sum_w;
  logic [8:0]  sum_b;
  logic [15:0] res;
  logic        r_msb;
  logic        a_msb;
  logic        b_msb;
  logic        s_msb;
  logic        z_flag;
  logic        carry;

  assign alu_out_add = op_src + op_dst;     // Plain sum for addressing

  assign sub_op   = (inst_op == exec_pkg::OP_SUB) | (inst_op == exec_pkg::OP_CMP);
  assign arith_op = sub_op | (inst_op == exec_pkg::OP_ADD) | (inst_op == exec_pkg::OP_ADDC);

  // dst - src as dst + ~src + 1
  assign add_b = sub_op ? ~op_src : op_src;
  assign cin   = sub_op | ((inst_op == exec_pkg::OP_ADDC) & status.c);

  assign sum_w = {1'b0, op_dst} + {1'b0, add_b} + {16'h0000, cin};
  assign sum_b = {1'b0, op_dst[7:0]} + {1'b0, add_b[7:0]} + {8'h00, cin};  // Byte carry out

  // ==============================
  // Result
  // ==============================
  always_comb begin
    unique case (inst_op)
      exec_pkg::OP_MOV:  res = op_src;
      exec_pkg::OP_AND,
      exec_pkg::OP_BIT:  res = op_src & op_dst;
      exec_pkg::OP_BIC:  res = ~op_src & op_dst;
      exec_pkg::OP_BIS:  res = op_src | op_dst;
      exec_pkg::OP_XOR:  res = op_src ^ op_dst;
      default:           res = sum_w[15:0];  // ADD, ADDC, SUB, CMP
    endcase
  end

  assign alu_out = res;                     // Upper byte cleared downstream for byte ops

  // Width dependent sign bits
  assign r_msb  = inst_bw ? res[7]    : res[15];
  assign a_msb  = inst_bw ? op_dst[7] : op_dst[15];
  assign b_msb  = inst_bw ? add_b[7]  : add_b[15];
  assign s_msb  = inst_bw ? op_src[7] : op_src[15];
  assign z_flag = inst_bw ? (res[7:0] == 8'h00) : (res == 16'h0000);
  assign carry  = inst_bw ? sum_b[8] : sum_w[16];

  // ==============================
  // Flags
  // ==============================
  always_comb begin
    alu_stat.n = r_msb;
    alu_stat.z = z_flag;
    if (arith_op) begin
      alu_stat.c = carry;                   // No-borrow for SUB and CMP
      alu_stat.v = (a_msb == b_msb) & (r_msb != a_msb);
    end else begin
      unique case (inst_op)
        exec_pkg::OP_AND,
        exec_pkg::OP_BIT: begin
          alu_stat.c = ~z_flag;
          alu_stat.v = 1'b0;
        end
        exec_pkg::OP_XOR: begin
          alu_stat.c = ~z_flag;
          alu_stat.v = s_msb & a_msb;       // Both operands negative
        end
        default: begin
          alu_stat.c = status.c;            // BIC, BIS keep carry
          alu_stat.v = 1'b0;
        end
      endcase
    end
  end

endmodule

/* src/exec_memory_port.sv */
// Memory bus interface
module exec_memory_port (
  input  logic                mclk,
  input  logic                puc_rst,
  input  exec_pkg::exec_state_t e_state,
  input  exec_pkg::mode_t     inst_as,
  input  exec_pkg::mode_t     inst_ad,
  input  exec_pkg::alu_op_t   inst_op,
  input  logic                inst_bw,
  input  logic [15:0]         alu_out,
  input  logic [15:0]         alu_out_add,  // Bus address
  input  logic [15:0]         mdb_in,
  output logic [15:0]         mab,
  output logic                mb_en,
  output logic [1:0]          mb_wr,        // Byte write strobes
  output logic [15:0]         mdb_out,
  output logic [15:0]         mdb_in_val,   // Source data, buffered when valid
  output logic [15:0]         mdb_in_bw     // Formatted current read data
);

  // ==============================
  // Bus cycle decode
  // ==============================
  logic        src_mem;
  logic        dst_mem;
  logic        rd_cycle;
  logic        wr_cycle;
  logic [1:0]  wr_msk;
  logic        mab_lsb;                     // Address lsb of last access
  logic        buf_en;
  logic        buf_valid;
  logic [15:0] in_buf;
  exec_pkg::mem_word_t rd_word;
  exec_pkg::mem_word_t fmt_word;

  assign src_mem  = inst_as[exec_pkg::MODE_IDX] | inst_as[exec_pkg::MODE_ABS];
  assign dst_mem  = inst_ad[exec_pkg::MODE_IDX] | inst_ad[exec_pkg::MODE_ABS];

  assign rd_cycle = ((e_state == exec_pkg::E_SRC_RD) & src_mem) |
                    ((e_state == exec_pkg::E_DST_RD) & dst_mem & exec_pkg::op_reads_dest(inst_op));
  assign wr_cycle = (e_state == exec_pkg::E_DST_WR) & ~exec_pkg::op_no_write(inst_op);

  assign wr_msk = ~inst_bw       ? 2'b11 :
                  alu_out_add[0] ? 2'b10 : 2'b01;   // Odd byte on high lane

  assign mab   = alu_out_add;
  assign mb_en = rd_cycle | wr_cycle;
  assign mb_wr = wr_cycle ? wr_msk : 2'b00;

  // Write data held from E_EXEC into E_DST_WR
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      mdb_out <= 16'h0000;
    end else if (e_state == exec_pkg::E_EXEC) begin
      mdb_out <= inst_bw ? {2{alu_out[7:0]}} : alu_out;  // Byte on both lanes
    end
  end

  // ==============================
  // Read data path
  // ==============================
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      mab_lsb <= 1'b0;
    end else if (mb_en) begin
      mab_lsb <= alu_out_add[0];
    end
  end

  always_comb begin
    rd_word.word  = mdb_in;
    fmt_word.word = rd_word.word;
    if (inst_bw) begin
      fmt_word.bytes.hi = 8'h00;
      fmt_word.bytes.lo = mab_lsb ? rd_word.bytes.hi : rd_word.bytes.lo;
    end
  end

  assign mdb_in_bw = fmt_word.word;

  // Source data arrives the cycle after E_SRC_RD
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      buf_en    <= 1'b0;
      buf_valid <= 1'b0;
    end else begin
      buf_en <= (e_state == exec_pkg::E_SRC_RD);
      if (e_state == exec_pkg::E_EXEC) begin
        buf_valid <= 1'b0;                  // Consumed by this instruction
      end else if (buf_en) begin
        buf_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge mclk) begin
    if (buf_en) begin
      in_buf <= mdb_in_bw;
    end
  end

  assign mdb_in_val = buf_valid ? in_buf : mdb_in_bw;

endmodule

/* src/exec_operand_select.sv */
// Operand selection per state
module exec_operand_select (
  input  exec_pkg::exec_state_t e_state,
  input  exec_pkg::mode_t     inst_as,      // Source mode
  input  exec_pkg::mode_t     inst_ad,      // Destination mode
  input  exec_pkg::alu_op_t   inst_op,
  input  logic [15:0]         reg_src,
  input  logic [15:0]         reg_dest,
  input  logic [15:0]         inst_sext,    // Source extension word
  input  logic [15:0]         inst_dext,    // Destination extension word
  input  logic [15:0]         mdb_in_val,   // Source read data, buffered
  input  logic [15:0]         mdb_in_bw,    // Current read data, formatted
  output logic [15:0]         op_src,
  output logic [15:0]         op_dst
);

  // ==============================
  // Address bases
  // ==============================
  logic [15:0] src_base;
  logic [15:0] dst_base;
  logic [15:0] src_data;
  logic [15:0] dst_data;

  assign src_base = inst_as[exec_pkg::MODE_ABS] ? 16'h0000 : reg_src;   // Absolute has no base
  assign dst_base = inst_ad[exec_pkg::MODE_ABS] ? 16'h0000 : reg_dest;

  // ==============================
  // Execute cycle data
  // ==============================
  always_comb begin
    if (inst_as[exec_pkg::MODE_DIR]) begin
      src_data = reg_src;                   // Register
    end else if (inst_as[exec_pkg::MODE_IMM]) begin
      src_data = inst_sext;                 // Immediate word
    end else begin
      src_data = mdb_in_val;                // Indexed or absolute read
    end
  end

  always_comb begin
    if (inst_ad[exec_pkg::MODE_DIR]) begin
      dst_data = reg_dest;
    end else if (exec_pkg::op_reads_dest(inst_op)) begin
      dst_data = mdb_in_bw;                 // Read issued in E_DST_RD
    end else begin
      dst_data = 16'h0000;                  // MOV leaves the bus idle
    end
  end

  // Address states feed base and offset to the adder
  always_comb begin
    unique case (e_state)
      exec_pkg::E_SRC_RD: begin
        op_src = src_base;
        op_dst = inst_sext;
      end
      exec_pkg::E_DST_RD, exec_pkg::E_DST_WR: begin
        op_src = dst_base;
        op_dst = inst_dext;
      end
      exec_pkg::E_EXEC: begin
        op_src = src_data;
        op_dst = dst_data;
      end
      default: begin
        op_src = 16'h0000;
        op_dst = 16'h0000;
      end
    endcase
  end

endmodule

/* src/exec_pkg.sv */
// Execution unit shared definitions
package exec_pkg;

  // ==============================
  // Execution states
  // ==============================
  typedef enum logic [3:0] {
    E_IDLE,                               // No operation
    E_SRC_RD,                             // Source operand read
    E_DST_RD,                             // Destination operand read
    E_EXEC,                               // ALU cycle
    E_DST_WR                              // Destination memory write
  } exec_state_t;

  // One-hot addressing mode, shared by source and destination
  typedef logic [3:0] mode_t;

  localparam int MODE_DIR = 0;            // Register direct
  localparam int MODE_IDX = 1;            // Indexed x(Rn)
  localparam int MODE_ABS = 2;            // Absolute &addr
  localparam int MODE_IMM = 3;            // Immediate #n, source only

  // ==============================
  // Two-operand ALU operations
  // ==============================
  typedef enum logic [3:0] {
    OP_MOV, OP_ADD, OP_ADDC, OP_SUB, OP_CMP,
    OP_AND, OP_BIT, OP_BIC, OP_BIS, OP_XOR
  } alu_op_t;

  // Compare and test only set flags
  function automatic logic op_no_write(input alu_op_t op);
    return (op == OP_CMP) || (op == OP_BIT);
  endfunction

  // Every op except MOV needs the old destination value
  function automatic logic op_reads_dest(input alu_op_t op);
    return (op != OP_MOV);
  endfunction

  // Status flags as kept in r2
  typedef struct packed {
    logic v;                              // Signed overflow
    logic n;                              // Negative
    logic z;                              // Zero
    logic c;                              // Carry
  } flags_t;

  // One bus word, seen whole or as two bytes
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] hi;                     // Odd address byte
      logic [7:0] lo;                     // Even address byte
    } bytes;
  } mem_word_t;

  localparam int REG_SP_IDX = 1;          // Stack pointer
  localparam int REG_SR_IDX = 2;          // Status register

endpackage

/* src/exec_register_file.sv */
// CPU register file
module exec_register_file (
  input  logic                mclk,
  input  logic                puc_rst,
  input  exec_pkg::exec_state_t e_state,
  input  exec_pkg::mode_t     inst_ad,      // Destination mode
  input  exec_pkg::alu_op_t   inst_op,
  input  logic                inst_bw,      // Byte op
  input  logic [15:0]         inst_src,     // Source select, one hot
  input  logic [15:0]         inst_dest,    // Destination select, one hot
  input  logic [15:0]         pc,           // r0 read value
  input  logic [15:0]         alu_out,
  input  exec_pkg::flags_t    alu_stat,
  output logic [15:0]         reg_src,
  output logic [15:0]         reg_dest,
  output exec_pkg::flags_t    status
);

  // ==============================
  // Storage and write control
  // ==============================
  logic [15:0] regs [1:15];                 // r1..r15, r0 lives outside
  logic [15:0] reg_view [16];               // Read view with pc as r0
  logic        exec_cycle;
  logic        dest_wr;                     // Register destination write
  logic        sr_upd;                      // Flag update
  logic [15:0] wr_val;
  logic [15:0] sp_val;

  assign exec_cycle = (e_state == exec_pkg::E_EXEC);
  assign dest_wr    = exec_cycle & inst_ad[exec_pkg::MODE_DIR] &
                      ~exec_pkg::op_no_write(inst_op);
  assign sr_upd     = exec_cycle & (inst_op != exec_pkg::OP_MOV);

  assign wr_val = inst_bw ? {8'h00, alu_out[7:0]} : alu_out;  // Byte op clears upper byte
  assign sp_val = {wr_val[15:1], 1'b0};     // SP stays word aligned

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      for (int i = 1; i < 16; i++) begin
        regs[i] <= 16'h0000;
      end
    end else begin
      if (sr_upd) begin
        regs[exec_pkg::REG_SR_IDX][0] <= alu_stat.c;
        regs[exec_pkg::REG_SR_IDX][1] <= alu_stat.z;
        regs[exec_pkg::REG_SR_IDX][2] <= alu_stat.n;
        regs[exec_pkg::REG_SR_IDX][8] <= alu_stat.v;
      end
      // An explicit write to r2 overrides the flag update
      if (dest_wr) begin
        for (int i = 1; i < 16; i++) begin
          if (inst_dest[i]) begin
            regs[i] <= (i == exec_pkg::REG_SP_IDX) ? sp_val : wr_val;
          end
        end
      end
    end
  end

  // ==============================
  // Read ports
  // ==============================
  always_comb begin
    reg_view[0] = pc;                       // r0 is the program counter
    for (int i = 1; i < 16; i++) begin
      reg_view[i] = regs[i];
    end
  end

  // One-hot select as an OR of masked registers
  always_comb begin
    reg_src  = 16'h0000;
    reg_dest = 16'h0000;
    for (int i = 0; i < 16; i++) begin
      if (inst_src[i]) begin
        reg_src = reg_src | reg_view[i];
      end
      if (inst_dest[i]) begin
        reg_dest = reg_dest | reg_view[i];
      end
    end
  end

  // Flags sit at bits 8, 2, 1, 0 of r2
  assign status.v = regs[exec_pkg::REG_SR_IDX][8];
  assign status.n = regs[exec_pkg::REG_SR_IDX][2];
  assign status.z = regs[exec_pkg::REG_SR_IDX][1];
  assign status.c = regs[exec_pkg::REG_SR_IDX][0];

endmodule

/* src/exec_unit.sv */
// Execution unit top level
module exec_unit (
  input  logic                mclk,
  input  logic                puc_rst,
  input  exec_pkg::exec_state_t e_state,    // From the sequencer
  input  exec_pkg::mode_t     inst_as,
  input  exec_pkg::mode_t     inst_ad,
  input  exec_pkg::alu_op_t   inst_op,
  input  logic                inst_bw,
  input  logic [15:0]         inst_src,
  input  logic [15:0]         inst_dest,
  input  logic [15:0]         inst_sext,
  input  logic [15:0]         inst_dext,
  input  logic [15:0]         pc,
  input  logic [15:0]         mdb_in,
  output logic [15:0]         mab,
  output logic [15:0]         mdb_out,
  output logic [15:0]         dbg_reg_din,
  output logic                mb_en,
  output logic [1:0]          mb_wr,
  output exec_pkg::flags_t    status
);

  logic [15:0]      reg_src;
  logic [15:0]      reg_dest;
  logic [15:0]      op_src;
  logic [15:0]      op_dst;
  logic [15:0]      alu_out;
  logic [15:0]      alu_out_add;
  logic [15:0]      mdb_in_val;
  logic [15:0]      mdb_in_bw;
  exec_pkg::flags_t alu_stat;

  assign dbg_reg_din = reg_dest;            // Debug view of selected destination

  exec_register_file i_register_file (
    .mclk, .puc_rst, .e_state, .inst_ad, .inst_op, .inst_bw,
    .inst_src, .inst_dest, .pc, .alu_out, .alu_stat,
    .reg_src, .reg_dest, .status
  );

  exec_operand_select i_operand_select (
    .e_state, .inst_as, .inst_ad, .inst_op, .reg_src, .reg_dest,
    .inst_sext, .inst_dext, .mdb_in_val, .mdb_in_bw,
    .op_src, .op_dst
  );

  exec_alu i_alu (
    .inst_op, .inst_bw, .op_src, .op_dst, .status,
    .alu_out, .alu_out_add, .alu_stat
  );

  exec_memory_port i_memory_port (
    .mclk, .puc_rst, .e_state, .inst_as, .inst_ad, .inst_op, .inst_bw,
    .alu_out, .alu_out_add, .mdb_in,
    .mab, .mb_en, .mb_wr, .mdb_out, .mdb_in_val, .mdb_in_bw
  );

endmodule

/* tb.f */
src/exec_pkg.sv
src/exec_register_file.sv
src/exec_operand_select.sv
src/exec_alu.sv
src/exec_memory_port.sv
src/exec_unit.sv
tests/exec_unit_properties.sv
tests/tb_exec_unit.sv

/* tests/exec_unit_properties.sv */
// Execution unit bound checks
module exec_unit_properties (
  input logic                  mclk,
  input logic                  puc_rst,
  input exec_pkg::exec_state_t e_state,
  input exec_pkg::mode_t       inst_as,
  input exec_pkg::mode_t       inst_ad,
  input exec_pkg::alu_op_t     inst_op,
  input logic                  inst_bw,
  input logic [15:0]           inst_sext,
  input logic [15:0]           inst_dext,
  input logic [15:0]           mdb_in,
  input logic [15:0]           mab,
  input logic                  mb_en,
  input logic [1:0]            mb_wr,
  input logic [15:0]           mdb_out,
  input exec_pkg::flags_t      status,
  input logic [15:0]           dbg_reg_din,
  input logic [15:0]           reg_src,
  input logic [15:0]           reg_dest
);

  int fail_count = 0;                       // Read by the testbench

  // ==============================
  // Reference ALU
  // ==============================
  // Returns {v, n, z, c, result}
  function automatic logic [19:0] ref_alu(input exec_pkg::alu_op_t op, input logic bw,
                                          input logic [15:0] s, input logic [15:0] d,
                                          input logic c_in);
    logic [15:0] msk;
    logic [16:0] sm;
    logic [16:0] dm;
    logic [16:0] t;
    logic [15:0] r;
    logic        s_neg;
    logic        d_neg;
    logic        r_neg;
    logic        z;
    logic        c;
    logic        v;
    msk = bw ? 16'h00ff : 16'hffff;
    sm  = {1'b0, s & msk};
    dm  = {1'b0, d & msk};
    case (op)
      exec_pkg::OP_MOV:  t = sm;
      exec_pkg::OP_ADD:  t = dm + sm;
      exec_pkg::OP_ADDC: t = dm + sm + {16'h0000, c_in};
      exec_pkg::OP_SUB,
      exec_pkg::OP_CMP:  t = dm - sm;
      exec_pkg::OP_AND,
      exec_pkg::OP_BIT:  t = dm & sm;
      exec_pkg::OP_BIC:  t = dm & ~sm;
      exec_pkg::OP_BIS:  t = dm | sm;
      exec_pkg::OP_XOR:  t = dm ^ sm;
      default:           t = 17'h00000;
    endcase
    r     = t[15:0] & msk;                  // Result at the width
    s_neg = bw ? s[7] : s[15];
    d_neg = bw ? d[7] : d[15];
    r_neg = bw ? r[7] : r[15];
    z     = (r == 16'h0000);
    c     = c_in;
    v     = 1'b0;
    case (op)
      exec_pkg::OP_ADD, exec_pkg::OP_ADDC: begin
        c = bw ? t[8] : t[16];              // Carry out
        v = (d_neg == s_neg) && (r_neg != d_neg);
      end
      exec_pkg::OP_SUB, exec_pkg::OP_CMP: begin
        c = (dm >= sm);                     // No borrow
        v = (d_neg != s_neg) && (r_neg != d_neg);
      end
      exec_pkg::OP_AND, exec_pkg::OP_BIT: c = !z;
      exec_pkg::OP_XOR: begin
        c = !z;
        v = s_neg & d_neg;                  // Both negative
      end
      default: c = c_in;                    // BIC, BIS hold carry
    endcase
    return {v, r_neg, z, c, r};
  endfunction

  // Byte lane pick of a read word
  function automatic logic [15:0] lane_pick(input logic [15:0] w, input logic lsb,
                                            input logic bw);
    if (!bw) begin
      return w;
    end
    return {8'h00, lsb ? w[15:8] : w[7:0]};
  endfunction

  // ==============================
  // Expected values
  // ==============================
  logic        rst_d;
  logic        src_rd_q;                    // Source data due this cycle
  logic        src_lsb_q;
  logic        dst_lsb_q;
  logic [15:0] src_buf_q;
  logic [15:0] src_val;
  logic [15:0] dst_val;
  logic [15:0] src_addr;
  logic [15:0] dst_addr;
  logic [19:0] ref_q;
  logic        no_wr;
  logic        is_exec;
  logic [1:0]  exp_strb;
  logic        chk_reg_q;
  logic        chk_keep_q;
  logic        chk_flags_q;
  logic [15:0] exp_res_q;
  logic [15:0] old_reg_q;
  logic [3:0]  exp_flags_q;
  logic [15:0] exp_wdata_q;

  assign no_wr    = exec_pkg::op_no_write(inst_op);
  assign is_exec  = (e_state == exec_pkg::E_EXEC);
  assign src_addr = inst_as[exec_pkg::MODE_ABS] ? inst_sext : reg_src + inst_sext;
  assign dst_addr = inst_ad[exec_pkg::MODE_ABS] ? inst_dext : reg_dest + inst_dext;
  assign exp_strb = no_wr ? 2'b00 : !inst_bw ? 2'b11 : dst_addr[0] ? 2'b10 : 2'b01;

  always_comb begin
    if (inst_as[exec_pkg::MODE_DIR]) begin
      src_val = reg_src;
    end else if (inst_as[exec_pkg::MODE_IMM]) begin
      src_val = inst_sext;
    end else begin
      src_val = src_rd_q ? lane_pick(mdb_in, src_lsb_q, inst_bw) : src_buf_q;
    end
    dst_val = inst_ad[exec_pkg::MODE_DIR] ? reg_dest : lane_pick(mdb_in, dst_lsb_q, inst_bw);
    ref_q   = ref_alu(inst_op, inst_bw, src_val, dst_val, status.c);
  end

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rst_d       <= 1'b1;
      src_rd_q    <= 1'b0;
      src_lsb_q   <= 1'b0;
      dst_lsb_q   <= 1'b0;
      src_buf_q   <= 16'h0000;
      chk_reg_q   <= 1'b0;
      chk_keep_q  <= 1'b0;
      chk_flags_q <= 1'b0;
      exp_res_q   <= 16'h0000;
      old_reg_q   <= 16'h0000;
      exp_flags_q <= 4'h0;
      exp_wdata_q <= 16'h0000;
    end else begin
      rst_d    <= 1'b0;
      src_rd_q <= (e_state == exec_pkg::E_SRC_RD);
      if (e_state == exec_pkg::E_SRC_RD) begin
        src_lsb_q <= mab[0];
      end
      if (src_rd_q) begin
        src_buf_q <= lane_pick(mdb_in, src_lsb_q, inst_bw);  // Held past E_DST_RD
      end
      if (e_state == exec_pkg::E_DST_RD) begin
        dst_lsb_q <= mab[0];
      end
      chk_reg_q   <= is_exec && inst_ad[exec_pkg::MODE_DIR] && !no_wr;
      chk_keep_q  <= is_exec && inst_ad[exec_pkg::MODE_DIR] && no_wr;
      chk_flags_q <= is_exec && (inst_op != exec_pkg::OP_MOV);
      exp_res_q   <= ref_q[15:0];
      old_reg_q   <= reg_dest;
      exp_flags_q <= ref_q[19:16];
      if (is_exec) begin
        exp_wdata_q <= inst_bw ? {2{ref_q[7:0]}} : ref_q[15:0];
      end
    end
  end

  // ==============================
  // Assertions
  // ==============================
  a_reset: assert property (@(posedge mclk) (puc_rst || rst_d) |->
      (!mb_en && mb_wr == 2'b00 && mdb_out == 16'h0000 && status == 4'h0))
    else begin
      fail_count++;
      $error("error %0t reset outputs mb_en=%b mb_wr=%b mdb_out=%h status=%h exp all 0",
             $time, $sampled(mb_en), $sampled(mb_wr), $sampled(mdb_out), $sampled(status));
    end

  a_src_rd: assert property (@(posedge mclk) disable iff (puc_rst)
      (e_state == exec_pkg::E_SRC_RD) |-> (mb_en && mb_wr == 2'b00 && mab == src_addr))
    else begin
      fail_count++;
      $error("error %0t mab got %h exp %h (mb_en=%b mb_wr=%b)", $time, $sampled(mab),
             $sampled(src_addr), $sampled(mb_en), $sampled(mb_wr));
    end

  a_dst_wr: assert property (@(posedge mclk) disable iff (puc_rst)
      (e_state == exec_pkg::E_DST_WR) |-> (mab == dst_addr && mb_wr == exp_strb))
    else begin
      fail_count++;
      $error("error %0t mab/mb_wr got %h/%b exp %h/%b", $time, $sampled(mab),
             $sampled(mb_wr), $sampled(dst_addr), $sampled(exp_strb));
    end

  a_wdata: assert property (@(posedge mclk) disable iff (puc_rst)
      (e_state == exec_pkg::E_DST_WR && !no_wr) |-> (mdb_out == exp_wdata_q))
    else begin
      fail_count++;
      $error("error %0t mdb_out got %h exp %h", $time, $sampled(mdb_out),
             $sampled(exp_wdata_q));
    end

  a_reg_wr: assert property (@(posedge mclk) disable iff (puc_rst)
      chk_reg_q |-> (dbg_reg_din == exp_res_q))
    else begin
      fail_count++;
      $error("error %0t dbg_reg_din got %h exp %h", $time, $sampled(dbg_reg_din),
             $sampled(exp_res_q));
    end

  a_reg_keep: assert property (@(posedge mclk) disable iff (puc_rst)
      chk_keep_q |-> (dbg_reg_din == old_reg_q))
    else begin
      fail_count++;
      $error("error %0t dbg_reg_din got %h exp %h", $time, $sampled(dbg_reg_din),
             $sampled(old_reg_q));
    end

  a_flags: assert property (@(posedge mclk) disable iff (puc_rst)
      chk_flags_q |-> (status == exp_flags_q))
    else begin
      fail_count++;
      $error("error %0t status got %h exp %h", $time, $sampled(status),
             $sampled(exp_flags_q));
    end

endmodule

bind exec_unit exec_unit_properties i_props (
  .mclk, .puc_rst, .e_state, .inst_as, .inst_ad, .inst_op, .inst_bw,
  .inst_sext, .inst_dext, .mdb_in, .mab, .mb_en, .mb_wr, .mdb_out,
  .status, .dbg_reg_din, .reg_src, .reg_dest
);

/* tests/tb_exec_unit.sv */
// Execution unit testbench
module tb_exec_unit;

  logic                  mclk;
  logic                  puc_rst;
  exec_pkg::exec_state_t e_state;
  exec_pkg::mode_t       inst_as;
  exec_pkg::mode_t       inst_ad;
  exec_pkg::alu_op_t     inst_op;
  logic                  inst_bw;
  logic [15:0]           inst_src;
  logic [15:0]           inst_dest;
  logic [15:0]           inst_sext;
  logic [15:0]           inst_dext;
  logic [15:0]           pc;
  logic [15:0]           mdb_in;
  logic [15:0]           mab;
  logic [15:0]           mdb_out;
  logic [15:0]           dbg_reg_din;
  logic                  mb_en;
  logic [1:0]            mb_wr;
  exec_pkg::flags_t      status;

  logic [31:0] seed = 32'h4e2c_1e60;
  logic [15:0] mem [32768];                 // Word memory model
  int          timeouts = 0;

  exec_unit i_exec_unit (.*);

  initial begin
    mclk = 1'b0;
    forever #20 mclk = ~mclk;
  end

  // Hard stop if the sequence hangs
  initial begin
    #400000;
    $display("timeout: simulation did not reach its end");
    $display("CHECKS FAILED");
    $finish;
  end

  // ==============================
  // Helpers
  // ==============================
  function automatic logic [15:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[31:16];
  endfunction

  function automatic exec_pkg::mode_t mode_onehot(input int idx);
    return exec_pkg::mode_t'(4'h1 << idx);
  endfunction

  // One cycle: serve last cycle's bus access, then drive the next state
  task automatic step(input exec_pkg::exec_state_t st);
    @(negedge mclk);
    if (mb_wr[0]) begin
      mem[mab[15:1]][7:0] = mdb_out[7:0];
    end
    if (mb_wr[1]) begin
      mem[mab[15:1]][15:8] = mdb_out[15:8];
    end
    if (mb_en && mb_wr == 2'b00) begin
      mdb_in = mem[mab[15:1]];              // Read data one cycle later
    end else begin
      mdb_in = next_rand();
    end
    e_state = st;
  endtask

  task automatic run_instr(input int as_idx, input int ad_idx, input exec_pkg::alu_op_t op,
                           input logic bw, input int s_idx, input int d_idx,
                           input logic [15:0] sext, input logic [15:0] dext);
    logic src_mem;
    logic dst_mem;
    exec_pkg::exec_state_t first;
    src_mem = (as_idx == exec_pkg::MODE_IDX) || (as_idx == exec_pkg::MODE_ABS);
    dst_mem = (ad_idx != exec_pkg::MODE_DIR);
    first   = src_mem ? exec_pkg::E_SRC_RD : dst_mem ? exec_pkg::E_DST_RD : exec_pkg::E_EXEC;
    step(first);
    inst_as   = mode_onehot(as_idx);
    inst_ad   = mode_onehot(ad_idx);
    inst_op   = op;
    inst_bw   = bw;
    inst_src  = 16'h0001 << s_idx;
    inst_dest = 16'h0001 << d_idx;
    inst_sext = sext;
    inst_dext = dext;
    if (first == exec_pkg::E_SRC_RD && dst_mem) begin
      step(exec_pkg::E_DST_RD);
    end
    if (first != exec_pkg::E_EXEC) begin
      step(exec_pkg::E_EXEC);
    end
    if (dst_mem) begin
      step(exec_pkg::E_DST_WR);
    end
    step(exec_pkg::E_IDLE);                 // Result visible here
  endtask

  task automatic wait_bus_idle();
    int n;
    n = 0;
    while (mb_en !== 1'b0 && n < 20) begin
      @(negedge mclk);
      n++;
    end
    if (mb_en !== 1'b0) begin
      timeouts++;
      $display("timeout: memory bus did not return to idle");
    end
  endtask

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    int errs;
    puc_rst = 1'b1;
    e_state = exec_pkg::E_IDLE;
    inst_as = mode_onehot(exec_pkg::MODE_DIR);
    inst_ad = mode_onehot(exec_pkg::MODE_DIR);
    inst_op = exec_pkg::OP_MOV;
    inst_bw = 1'b0;
    inst_src  = 16'h0008;
    inst_dest = 16'h0008;
    inst_sext = 16'h0000;
    inst_dext = 16'h0000;
    pc      = 16'hc000;
    mdb_in  = 16'h0000;
    for (int i = 0; i < 32768; i++) begin
      mem[i] = 16'(i * 27491 + 11551);      // Address dependent fill
    end
    repeat (3) @(negedge mclk);
    puc_rst = 1'b0;
    step(exec_pkg::E_IDLE);
    step(exec_pkg::E_IDLE);
    wait_bus_idle();
    for (int r = 3; r < 16; r++) begin      // Preload r3..r15
      run_instr(exec_pkg::MODE_IMM, exec_pkg::MODE_DIR, exec_pkg::OP_MOV, 1'b0, 3, r,
                next_rand(), 16'h0000);
    end
    // Source reads into registers, word and both byte lanes
    run_instr(exec_pkg::MODE_ABS, exec_pkg::MODE_DIR, exec_pkg::OP_MOV, 1'b0, 3, 4,
              16'h1234, 16'h0000);
    run_instr(exec_pkg::MODE_IDX, exec_pkg::MODE_DIR, exec_pkg::OP_MOV, 1'b1, 5, 6,
              16'h0011, 16'h0000);
    run_instr(exec_pkg::MODE_ABS, exec_pkg::MODE_DIR, exec_pkg::OP_MOV, 1'b1, 3, 7,
              16'h2220, 16'h0000);
    // No-write ops on register and memory
    run_instr(exec_pkg::MODE_IMM, exec_pkg::MODE_DIR, exec_pkg::OP_CMP, 1'b0, 3, 8,
              16'h7fff, 16'h0000);
    run_instr(exec_pkg::MODE_IMM, exec_pkg::MODE_ABS, exec_pkg::OP_BIT, 1'b1, 3, 9,
              16'h00f0, 16'h3001);
    for (int k = 0; k < 80; k++) begin
      run_instr(int'(next_rand() % 16'd4), int'(next_rand() % 16'd3),
                exec_pkg::alu_op_t'(4'(next_rand() % 16'd10)), next_rand() > 16'h7fff,
                3 + int'(next_rand() % 16'd13), 3 + int'(next_rand() % 16'd13),
                next_rand(), next_rand());
    end
    wait_bus_idle();
    step(exec_pkg::E_IDLE);
    errs = i_exec_unit.i_props.fail_count + timeouts;
    $display("assertion failures: %0d, timeouts: %0d", i_exec_unit.i_props.fail_count,
             timeouts);
    if (errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
